// File: verilog/chip_link_cfg.svh
////////////////////////////////////////
// Flit width must be a whole multiple of the tag payload width
// Link credits must be at least 2 and match the inbound FIFO depth
////////////////////////////////////////
`ifndef CHIP_LINK_CFG_SVH
`define CHIP_LINK_CFG_SVH

// Link datapath
`define CHIP_FLIT_WIDTH 16
`define CHIP_LINK_CREDITS 4

// Tag frame layout, start bit then opcode then payload
`define CHIP_TAG_OP_WIDTH 2
`define CHIP_TAG_PAYLOAD_WIDTH 8
`define CHIP_TAG_FRAME_BITS (1 + `CHIP_TAG_OP_WIDTH + `CHIP_TAG_PAYLOAD_WIDTH)

`endif

// File: verilog/chip_link_pkg.sv
////////////////////////////////////////
// Types shared by the chip block datapath and control
////////////////////////////////////////
`include "chip_link_cfg.svh"

package chip_link_pkg;

  // Tag bus opcodes
  typedef enum logic [`CHIP_TAG_OP_WIDTH-1:0] {
    TAG_NOP        = 2'd0,
    TAG_WRITE_MODE = 2'd1,
    TAG_WRITE_KEY  = 2'd2,
    TAG_LINK_RESET = 2'd3
  } tag_op_e;

  typedef struct packed {
    tag_op_e                            op;
    logic [`CHIP_TAG_PAYLOAD_WIDTH-1:0] payload;
  } tag_cmd_s;

  typedef enum logic [1:0] {
    XF_PASS    = 2'd0,
    XF_INVERT  = 2'd1,
    XF_XOR_KEY = 2'd2,
    XF_ADD_KEY = 2'd3
  } xform_mode_e;

  typedef enum logic [1:0] {
    CTRL_RESET      = 2'd0,
    CTRL_DISABLED   = 2'd1,
    CTRL_LINK_RESET = 2'd2,
    CTRL_ACTIVE     = 2'd3
  } ctrl_state_e;

  typedef struct packed {
    xform_mode_e                        mode;
    logic [`CHIP_TAG_PAYLOAD_WIDTH-1:0] key;
  } xform_cfg_s;

  typedef struct packed {
    logic [`CHIP_FLIT_WIDTH-1:0] payload;
  } flit_s;

endpackage

// File: verilog/chip_tag_client.sv
////////////////////////////////////////
// Frames need tag_en_i high from start bit to last bit
////////////////////////////////////////
`timescale 1ns/1ps
`include "chip_link_cfg.svh"

module chip_tag_client
  import chip_link_pkg::*;
 (input  logic     clk_i
 ,input  logic     rst_i
 ,input  logic     tag_en_i
 ,input  logic     tag_data_i
 ,output logic     cmd_v_o
 ,output tag_cmd_s cmd_o
 );

  // Opcode plus payload bits after the start bit
  localparam int BODY_BITS = `CHIP_TAG_FRAME_BITS - 1;
  localparam int CNT_W     = $clog2(BODY_BITS);

  logic                 tag_bit;
  logic                 busy_r;
  logic [CNT_W-1:0]     bit_cnt_r;
  logic [BODY_BITS-2:0] shift_r;
  logic                 done;

  // Enable gates the data pin
  assign tag_bit = tag_en_i & tag_data_i;

  assign done = busy_r && tag_en_i && (bit_cnt_r == CNT_W'(BODY_BITS - 1));

  ////////////////////////////////////////
  // Framing
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      busy_r    <= 1'b0;
      bit_cnt_r <= '0;
      cmd_v_o   <= 1'b0;
    end
    else
    begin
      cmd_v_o <= done;
      if (!busy_r)
      begin
        // Idle until a start bit
        if (tag_bit)
        begin
          busy_r    <= 1'b1;
          bit_cnt_r <= '0;
        end
      end
      else if (!tag_en_i)
      begin
        // Enable fell mid-frame, drop it
        busy_r <= 1'b0;
      end
      else if (done)
      begin
        busy_r <= 1'b0;
      end
      else
      begin
        bit_cnt_r <= bit_cnt_r + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Deserializer
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (busy_r && tag_en_i)
    begin
      shift_r <= {shift_r[BODY_BITS-3:0], tag_bit};
    end
    if (done)
    begin
      // MSB first, last bit lands in payload bit 0
      cmd_o <= tag_cmd_s'({shift_r, tag_bit});
    end
  end

endmodule

// File: verilog/chip_block_ctrl.sv
////////////////////////////////////////
// Link reset is only honored while the link is disabled
////////////////////////////////////////
`timescale 1ns/1ps
`include "chip_link_cfg.svh"

module chip_block_ctrl
  import chip_link_pkg::*;
 (input  logic       clk_i
 ,input  logic       rst_i
 ,input  logic       cmd_v_i
 ,input  tag_cmd_s   cmd_i
 ,output xform_cfg_s cfg_o
 ,output logic       link_en_o
 ,output logic       link_reset_o
 );

  ctrl_state_e state_r;
  xform_cfg_s  cfg_r;

  logic cmd_ok;
  logic mode_wr;
  logic key_wr;
  logic reset_req;
  logic en_bit;

  // Config writes accepted in the two steady states
  assign cmd_ok    = cmd_v_i && (state_r == CTRL_DISABLED || state_r == CTRL_ACTIVE);
  assign mode_wr   = cmd_ok && (cmd_i.op == TAG_WRITE_MODE);
  assign key_wr    = cmd_ok && (cmd_i.op == TAG_WRITE_KEY);
  assign reset_req = cmd_v_i && (cmd_i.op == TAG_LINK_RESET) && (state_r == CTRL_DISABLED);
  assign en_bit    = cmd_i.payload[`CHIP_TAG_PAYLOAD_WIDTH-1];

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_r <= CTRL_RESET;
    end
    else
    begin
      case (state_r)
        CTRL_RESET:
        begin
          state_r <= CTRL_DISABLED;
        end
        CTRL_DISABLED:
        begin
          if (mode_wr && en_bit)
          begin
            state_r <= CTRL_ACTIVE;
          end
          else if (reset_req)
          begin
            state_r <= CTRL_LINK_RESET;
          end
        end
        // One cycle pulse then back
        CTRL_LINK_RESET:
        begin
          state_r <= CTRL_DISABLED;
        end
        CTRL_ACTIVE:
        begin
          if (mode_wr && !en_bit)
          begin
            state_r <= CTRL_DISABLED;
          end
        end
        default:
        begin
          state_r <= CTRL_DISABLED;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Config registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      cfg_r.mode <= XF_PASS;
      cfg_r.key  <= '0;
    end
    else
    begin
      if (mode_wr)
      begin
        cfg_r.mode <= xform_mode_e'(cmd_i.payload[1:0]);
      end
      if (key_wr)
      begin
        cfg_r.key <= cmd_i.payload;
      end
    end
  end

  assign cfg_o        = cfg_r;
  assign link_en_o    = (state_r == CTRL_ACTIVE);
  assign link_reset_o = (state_r == CTRL_LINK_RESET);

endmodule

// File: verilog/chip_link_downstream.sv
////////////////////////////////////////
// Sender must respect its tokens; a push into a full FIFO is dropped
////////////////////////////////////////
`timescale 1ns/1ps
`include "chip_link_cfg.svh"

module chip_link_downstream
  import chip_link_pkg::*;
 (input  logic  clk_i
 ,input  logic  rst_i
 ,input  logic  link_reset_i
 ,input  logic  in_v_i
 ,input  flit_s in_data_i
 ,output logic  in_tok_o
 ,output logic  deq_v_o
 ,output flit_s deq_o
 ,input  logic  deq_ready_i
 );

  localparam int DEPTH = `CHIP_LINK_CREDITS;
  localparam int PTR_W = $clog2(DEPTH);

  flit_s            mem_r [DEPTH];
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [PTR_W:0]   count_r;

  logic push;
  logic wr;
  logic pop;
  logic full;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign push    = in_v_i;
  assign full    = (count_r == (PTR_W+1)'(DEPTH));
  assign wr      = push && !full;
  assign deq_v_o = (count_r != '0);
  assign deq_o   = mem_r[rd_ptr_r];
  assign pop     = deq_v_o && deq_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i || link_reset_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
      in_tok_o <= 1'b0;
    end
    else
    begin
      // One token back per flit leaving the FIFO
      in_tok_o <= pop;
      if (wr)
      begin
        wr_ptr_r <= next_ptr(wr_ptr_r);
      end
      if (pop)
      begin
        rd_ptr_r <= next_ptr(rd_ptr_r);
      end
      case ({wr, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i)
  begin
    if (wr)
    begin
      mem_r[wr_ptr_r] <= in_data_i;
    end
  end

endmodule

// File: verilog/chip_flit_xform.sv
////////////////////////////////////////
// Mode and key are sampled when a flit is taken
////////////////////////////////////////
`timescale 1ns/1ps
`include "chip_link_cfg.svh"

module chip_flit_xform
  import chip_link_pkg::*;
 (input  logic       clk_i
 ,input  logic       rst_i
 ,input  xform_cfg_s cfg_i
 ,input  logic       v_i
 ,input  flit_s      data_i
 ,output logic       ready_o
 ,output logic       v_o
 ,output flit_s      data_o
 ,input  logic       ready_i
 );

  localparam int FLIT_W   = `CHIP_FLIT_WIDTH;
  localparam int KEY_REPS = `CHIP_FLIT_WIDTH / `CHIP_TAG_PAYLOAD_WIDTH;

  function automatic flit_s xform_apply(input flit_s f, input xform_cfg_s c);
    flit_s r;
    r = f;
    case (c.mode)
      XF_INVERT:  r.payload = ~f.payload;
      XF_XOR_KEY: r.payload = f.payload ^ {KEY_REPS{c.key}};
      // Wraps modulo the flit width
      XF_ADD_KEY: r.payload = f.payload + FLIT_W'(c.key);
      default:    r.payload = f.payload;
    endcase
    return r;
  endfunction

  // Room when empty or draining this cycle
  assign ready_o = !v_o || ready_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      v_o <= 1'b0;
    end
    else if (v_i && ready_o)
    begin
      v_o <= 1'b1;
    end
    else if (ready_i)
    begin
      v_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (v_i && ready_o)
    begin
      data_o <= xform_apply(data_i, cfg_i);
    end
  end

endmodule

// File: verilog/chip_link_upstream.sv
////////////////////////////////////////
// Receiver returns one out_tok_i pulse per flit it frees
////////////////////////////////////////
`timescale 1ns/1ps
`include "chip_link_cfg.svh"

module chip_link_upstream
  import chip_link_pkg::*;
 (input  logic  clk_i
 ,input  logic  rst_i
 ,input  logic  link_reset_i
 ,input  logic  link_en_i
 ,input  logic  v_i
 ,input  flit_s data_i
 ,input  logic  out_tok_i
 ,output logic  ready_o
 ,output logic  out_v_o
 ,output flit_s out_data_o
 );

  localparam int CREDITS = `CHIP_LINK_CREDITS;
  localparam int CNT_W   = $clog2(CREDITS + 1);

  logic [CNT_W-1:0] credit_r;
  logic             send;

  // Only send while enabled and holding a credit
  assign ready_o = link_en_i && (credit_r != '0);
  assign send    = v_i && ready_o;

  ////////////////////////////////////////
  // Credit counter and link valid
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (rst_i || link_reset_i)
    begin
      credit_r <= CNT_W'(CREDITS);
      out_v_o  <= 1'b0;
    end
    else
    begin
      out_v_o  <= send;
      // Send and token return may land in the same cycle
      credit_r <= credit_r - CNT_W'(send) + CNT_W'(out_tok_i);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (send)
    begin
      out_data_o <= data_i;
    end
  end

endmodule

// File: verilog/chip_block.sv
////////////////////////////////////////
// Single clock domain, one inbound and one outbound link
////////////////////////////////////////
`timescale 1ns/1ps

module chip_block
  import chip_link_pkg::*;
 (input  logic  clk_i
 ,input  logic  rst_i
 ,input  logic  tag_en_i
 ,input  logic  tag_data_i
 ,input  logic  in_v_i
 ,input  flit_s in_data_i
 ,output logic  in_tok_o
 ,output logic  out_v_o
 ,output flit_s out_data_o
 ,input  logic  out_tok_i
 );

  tag_cmd_s   tag_cmd;
  logic       tag_cmd_v;
  xform_cfg_s xform_cfg;
  logic       link_en;
  logic       link_reset;

  logic  deq_v;
  logic  deq_ready;
  flit_s deq_data;
  logic  xf_v;
  logic  xf_ready;
  flit_s xf_data;

  ////////////////////////////////////////
  // Tag and control
  ////////////////////////////////////////

  chip_tag_client tag_client
  (.clk_i      (clk_i     )
  ,.rst_i      (rst_i     )
  ,.tag_en_i   (tag_en_i  )
  ,.tag_data_i (tag_data_i)
  ,.cmd_v_o    (tag_cmd_v )
  ,.cmd_o      (tag_cmd   )
  );

  chip_block_ctrl ctrl
  (.clk_i        (clk_i     )
  ,.rst_i        (rst_i     )
  ,.cmd_v_i      (tag_cmd_v )
  ,.cmd_i        (tag_cmd   )
  ,.cfg_o        (xform_cfg )
  ,.link_en_o    (link_en   )
  ,.link_reset_o (link_reset)
  );

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  chip_link_downstream link_in
  (.clk_i        (clk_i     )
  ,.rst_i        (rst_i     )
  ,.link_reset_i (link_reset)
  ,.in_v_i       (in_v_i    )
  ,.in_data_i    (in_data_i )
  ,.in_tok_o     (in_tok_o  )
  ,.deq_v_o      (deq_v     )
  ,.deq_o        (deq_data  )
  ,.deq_ready_i  (deq_ready )
  );

  chip_flit_xform xform
  (.clk_i   (clk_i    )
  ,.rst_i   (rst_i    )
  ,.cfg_i   (xform_cfg)
  ,.v_i     (deq_v    )
  ,.data_i  (deq_data )
  ,.ready_o (deq_ready)
  ,.v_o     (xf_v     )
  ,.data_o  (xf_data  )
  ,.ready_i (xf_ready )
  );

  chip_link_upstream link_out
  (.clk_i        (clk_i     )
  ,.rst_i        (rst_i     )
  ,.link_reset_i (link_reset)
  ,.link_en_i    (link_en   )
  ,.v_i          (xf_v      )
  ,.data_i       (xf_data   )
  ,.out_tok_i    (out_tok_i )
  ,.ready_o      (xf_ready  )
  ,.out_v_o      (out_v_o   )
  ,.out_data_o   (out_data_o)
  );

endmodule

// File: tb/chip_block_checker.sv
////////////////////////////////////////
// Watches internal credit and FIFO state of chip_block through bind
////////////////////////////////////////
`timescale 1ns/1ps
`include "chip_link_cfg.svh"

module chip_block_checker
 #(parameter int CNT_W  = $clog2(`CHIP_LINK_CREDITS + 1)
  ,parameter int FILL_W = $clog2(`CHIP_LINK_CREDITS) + 1
  ,parameter int PTR_W  = $clog2(`CHIP_LINK_CREDITS)
  )
 (input logic              clk_i
 ,input logic              rst_i
 ,input logic              link_reset_i
 ,input logic              in_v_i
 ,input logic              in_tok_i
 ,input logic              out_v_i
 ,input logic              out_tok_i
 ,input logic [PTR_W-1:0]  rd_ptr_i
 ,input logic [CNT_W-1:0]  credit_i
 ,input logic [FILL_W-1:0] fifo_count_i
 );

  localparam int CREDITS = `CHIP_LINK_CREDITS;

  logic             tok_d_r;
  logic [CNT_W-1:0] unpaid_r;

  // Flits seen on the link less tokens the sender has already counted
  always_ff @(posedge clk_i)
  begin
    if (rst_i || link_reset_i)
    begin
      tok_d_r  <= 1'b0;
      unpaid_r <= '0;
    end
    else
    begin
      tok_d_r  <= out_tok_i;
      unpaid_r <= unpaid_r + CNT_W'(out_v_i) - CNT_W'(tok_d_r);
    end
  end

  credit_max: assert property (@(posedge clk_i) disable iff (rst_i)
    credit_i <= CNT_W'(CREDITS))
    else $error("Upstream credit count above %0d", CREDITS);

  // A flit on the link must have been sent while holding a credit
  send_credit: assert property (@(posedge clk_i) disable iff (rst_i)
    out_v_i |-> unpaid_r < CNT_W'(CREDITS))
    else $error("out_v_o raised with no upstream credit");

  fifo_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    !(in_v_i && fifo_count_i == FILL_W'(CREDITS)))
    else $error("Inbound flit pushed into a full FIFO");

  // A pop moves the read pointer
  tok_on_pop: assert property (@(posedge clk_i) disable iff (rst_i)
    in_tok_i |-> rd_ptr_i != $past(rd_ptr_i))
    else $error("in_tok_o pulsed without a FIFO pop");

endmodule

bind chip_block chip_block_checker checker_i
  (.clk_i        (clk_i             )
  ,.rst_i        (rst_i             )
  ,.link_reset_i (link_reset        )
  ,.in_v_i       (in_v_i            )
  ,.in_tok_i     (in_tok_o          )
  ,.out_v_i      (out_v_o           )
  ,.out_tok_i    (out_tok_i         )
  ,.rd_ptr_i     (link_in.rd_ptr_r  )
  ,.credit_i     (link_out.credit_r )
  ,.fifo_count_i (link_in.count_r   )
  );

// File: tb/chip_block_tb.sv
////////////////////////////////////////
// Inputs change on the falling edge, the run stops at the first mismatch
////////////////////////////////////////
`timescale 1ns/1ps
`include "chip_link_cfg.svh"

module chip_block_tb
  import chip_link_pkg::*;
  ();

  localparam int CLK_PERIOD = 40;
  localparam int CREDITS    = `CHIP_LINK_CREDITS;
  localparam int FRAME_BITS = `CHIP_TAG_FRAME_BITS;
  localparam int FLIT_W     = `CHIP_FLIT_WIDTH;
  // Flits and tag frames over all tests
  localparam int TOTAL_FLITS    = 63;
  localparam int TAG_FRAMES     = 11;
  localparam int TIMEOUT_CYCLES = TOTAL_FLITS * 6 + TAG_FRAMES * (FRAME_BITS + 5) + 600;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic  clk_i;
  logic  rst_i;
  logic  tag_en_i;
  logic  tag_data_i;
  logic  in_v_i;
  flit_s in_data_i;
  logic  in_tok_o;
  logic  out_v_o;
  flit_s out_data_o;
  logic  out_tok_i = 1'b0;

  logic [31:0] lfsr_state  = 32'd76323;
  xform_mode_e cfg_mode    = XF_PASS;
  logic [7:0]  cfg_key     = '0;
  flit_s       exp_q [$];
  int          tokens      = CREDITS;
  int          sent_total  = 0;
  int          tok_total   = 0;
  int          out_count   = 0;
  int          pending_tok = 0;
  logic        withhold    = 1'b0;

  chip_block uut
  (.clk_i      (clk_i     )
  ,.rst_i      (rst_i     )
  ,.tag_en_i   (tag_en_i  )
  ,.tag_data_i (tag_data_i)
  ,.in_v_i     (in_v_i    )
  ,.in_data_i  (in_data_i )
  ,.in_tok_o   (in_tok_o  )
  ,.out_v_o    (out_v_o   )
  ,.out_data_o (out_data_o)
  ,.out_tok_i  (out_tok_i )
  );

  initial
  begin
    clk_i = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Transform as the mode table defines it
  function automatic flit_s expected_flit(input flit_s f, input xform_mode_e mode,
                                          input logic [7:0] key);
    flit_s r;
    case (mode)
      XF_INVERT:  r.payload = f.payload ^ 16'hFFFF;
      XF_XOR_KEY: r.payload = f.payload ^ {key, key};
      XF_ADD_KEY: r.payload = f.payload + {8'h00, key};
      default:    r.payload = f.payload;
    endcase
    return r;
  endfunction

  task automatic report_fail();
    $display("** FAIL **");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_flit(input string name, input flit_s actual, input flit_s expected);
    if (actual !== expected)
    begin
      $display("FAIL at %0t: %s = %h, expected %h", $time, name, actual.payload,
               expected.payload);
      report_fail();
    end
  endtask

  task automatic check_count(input string name, input int actual, input int expected);
    if (actual != expected)
    begin
      $display("FAIL at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
      report_fail();
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  // Start bit, opcode and payload MSB first, cut after nbits
  task automatic shift_frame(input tag_op_e op, input logic [7:0] payload, input int nbits);
    logic [FRAME_BITS-1:0] frame;
    int                    i;
    frame = {1'b1, op, payload};
    for (i = 0; i < nbits; i++)
    begin
      tag_en_i   = 1'b1;
      tag_data_i = frame[FRAME_BITS-1-i];
      @(negedge clk_i);
    end
    tag_en_i   = 1'b0;
    tag_data_i = 1'b0;
    wait_cycles(3);
  endtask

  task automatic write_mode(input xform_mode_e mode, input logic en);
    shift_frame(TAG_WRITE_MODE, {en, 5'b0, mode}, FRAME_BITS);
    cfg_mode = mode;
  endtask

  task automatic write_key(input logic [7:0] key);
    shift_frame(TAG_WRITE_KEY, key, FRAME_BITS);
    cfg_key = key;
  endtask

  task automatic send_flits(input int n);
    flit_s f;
    int    i;
    for (i = 0; i < n; i++)
    begin
      // Hold off while out of tokens
      while (tokens == 0)
      begin
        in_v_i = 1'b0;
        @(negedge clk_i);
      end
      f.payload  = FLIT_W'(random_bits(FLIT_W));
      in_v_i     = 1'b1;
      in_data_i  = f;
      tokens     = tokens - 1;
      sent_total = sent_total + 1;
      exp_q.push_back(expected_flit(f, cfg_mode, cfg_key));
      @(negedge clk_i);
    end
    in_v_i = 1'b0;
  endtask

  task automatic drain_and_check();
    while (exp_q.size() != 0)
    begin
      @(negedge clk_i);
    end
    wait_cycles(8);
    check_count("in_tok_o tokens held", tokens, CREDITS);
    check_count("in_tok_o pulses", tok_total, sent_total);
  endtask

  ////////////////////////////////////////
  // Monitors and token model
  ////////////////////////////////////////

  always @(negedge clk_i)
  begin
    if (!rst_i && in_tok_o)
    begin
      tokens    = tokens + 1;
      tok_total = tok_total + 1;
    end
  end

  always @(negedge clk_i)
  begin
    if (!rst_i && out_v_o)
    begin
      if (exp_q.size() == 0)
      begin
        $display("Flit %h appeared on out_data_o at %0t with none outstanding",
                 out_data_o.payload, $time);
        report_fail();
      end
      else
      begin
        check_flit("out_data_o", out_data_o, exp_q.pop_front());
        out_count   = out_count + 1;
        pending_tok = pending_tok + 1;
      end
    end
  end

  always @(negedge clk_i)
  begin
    out_tok_i = 1'b0;
    if (!withhold && pending_tok > 0)
    begin
      out_tok_i   = 1'b1;
      pending_tok = pending_tok - 1;
    end
  end

  initial
  begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout at %0t: tests did not finish within %0d cycles", $time,
             TIMEOUT_CYCLES);
    report_fail();
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial
  begin
    int          i;
    int          base;
    logic [7:0]  key;
    rst_i      = 1'b1;
    tag_en_i   = 1'b0;
    tag_data_i = 1'b0;
    in_v_i     = 1'b0;
    in_data_i  = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    // Quiet after reset, nothing leaves while disabled
    wait_cycles(8);
    check_count("out_v_o flits after reset", out_count, 0);
    check_count("in_tok_o pulses after reset", tok_total, 0);
    send_flits(3);
    wait_cycles(12);
    check_count("out_v_o flits while disabled", out_count, 0);

    write_mode(XF_PASS, 1'b1);
    send_flits(12);
    drain_and_check();

    // Every mode but XF_PASS
    for (i = 1; i < 4; i++)
    begin
      key = 8'(random_bits(8));
      write_key(key);
      write_mode(xform_mode_e'(i), 1'b1);
      send_flits(8);
      drain_and_check();
    end

    // Withheld tokens stall the link after the credits run out
    base     = out_count;
    withhold = 1'b1;
    send_flits(8);
    wait_cycles(16);
    check_count("out_v_o flits on withheld tokens", out_count - base, CREDITS);
    wait_cycles(10);
    check_count("out_v_o flits still stalled", out_count - base, CREDITS);
    withhold = 1'b0;
    drain_and_check();

    // Disable mid-stream; link reset while active must be ignored
    base     = out_count;
    withhold = 1'b1;
    send_flits(8);
    wait_cycles(16);
    shift_frame(TAG_LINK_RESET, 8'h00, FRAME_BITS);
    write_mode(cfg_mode, 1'b0);
    withhold = 1'b0;
    wait_cycles(16);
    check_count("out_v_o flits while disabled", out_count - base, CREDITS);
    write_mode(cfg_mode, 1'b1);
    drain_and_check();

    // Cut frame and gated noise leave the key alone
    shift_frame(TAG_WRITE_KEY, ~cfg_key, 6);
    for (i = 0; i < 8; i++)
    begin
      tag_data_i = ~tag_data_i;
      @(negedge clk_i);
    end
    tag_data_i = 1'b0;
    wait_cycles(3);
    send_flits(8);
    drain_and_check();

    $display("** PASS **");
    $finish;
  end

endmodule

// File: chip_link.f
+incdir+verilog
verilog/chip_link_pkg.sv
verilog/chip_tag_client.sv
verilog/chip_block_ctrl.sv
verilog/chip_link_downstream.sv
verilog/chip_flit_xform.sv
verilog/chip_link_upstream.sv
verilog/chip_block.sv
tb/chip_block_checker.sv
tb/chip_block_tb.sv
